/* hw/core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

	// AXI4 field widths.
	localparam int addr_width = 32;
	localparam int data_width = 64;
	localparam int id_width = 4;
	localparam int strb_width = 8;
	localparam int len_width = 8;
	localparam int size_width = 3;
	localparam int burst_width = 2;
	localparam int resp_width = 2;

	// CLINT window, inclusive at both ends.
	localparam logic [addr_width-1:0] clint_base = 32'h0200_0000;
	localparam logic [addr_width-1:0] clint_limit = 32'h0200_ffff;

	// Machine timer, the only readable CLINT register.
	localparam logic [addr_width-1:0] clint_mtime_addr = 32'h0200_bff8;

	// Owner of the shared bus.
	typedef enum logic [2:0] {
		grant_idle,
		grant_ifu_read,
		grant_lsu_read,
		grant_clint_read,
		grant_lsu_write
	} grant_state_t;

	// Response codes in use.
	typedef enum logic [resp_width-1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

/* hw/axi_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_interconnect import core_bus_pkg::*; (
	input wire clock,
	input wire reset,

	// Instruction fetch read.
	input wire ifu_arvalid,
	input wire [addr_width-1:0] ifu_araddr,
	input wire [id_width-1:0] ifu_arid,
	input wire [len_width-1:0] ifu_arlen,
	input wire [size_width-1:0] ifu_arsize,
	input wire [burst_width-1:0] ifu_arburst,
	input wire ifu_rready,
	output logic ifu_arready,
	output logic ifu_rvalid,
	output logic [resp_width-1:0] ifu_rresp,
	output logic [data_width-1:0] ifu_rdata,
	output logic ifu_rlast,
	output logic [id_width-1:0] ifu_rid,

	// Load/store read.
	input wire lsu_arvalid,
	input wire [addr_width-1:0] lsu_araddr,
	input wire [id_width-1:0] lsu_arid,
	input wire [len_width-1:0] lsu_arlen,
	input wire [size_width-1:0] lsu_arsize,
	input wire [burst_width-1:0] lsu_arburst,
	input wire lsu_rready,
	output logic lsu_arready,
	output logic lsu_rvalid,
	output logic [resp_width-1:0] lsu_rresp,
	output logic [data_width-1:0] lsu_rdata,
	output logic lsu_rlast,
	output logic [id_width-1:0] lsu_rid,

	// Load/store write.
	input wire lsu_awvalid,
	input wire [addr_width-1:0] lsu_awaddr,
	input wire [id_width-1:0] lsu_awid,
	input wire [len_width-1:0] lsu_awlen,
	input wire [size_width-1:0] lsu_awsize,
	input wire [burst_width-1:0] lsu_awburst,
	input wire lsu_wvalid,
	input wire [data_width-1:0] lsu_wdata,
	input wire [strb_width-1:0] lsu_wstrb,
	input wire lsu_wlast,
	input wire lsu_bready,
	output logic lsu_awready,
	output logic lsu_wready,
	output logic lsu_bvalid,
	output logic [resp_width-1:0] lsu_bresp,
	output logic [id_width-1:0] lsu_bid,

	// On-chip CLINT.
	output logic clint_arvalid,
	output logic [addr_width-1:0] clint_araddr,
	output logic [id_width-1:0] clint_arid,
	output logic [len_width-1:0] clint_arlen,
	output logic [size_width-1:0] clint_arsize,
	output logic [burst_width-1:0] clint_arburst,
	output logic clint_rready,
	input wire clint_arready,
	input wire clint_rvalid,
	input wire [resp_width-1:0] clint_rresp,
	input wire [data_width-1:0] clint_rdata,
	input wire clint_rlast,
	input wire [id_width-1:0] clint_rid,

	// External AXI4 master port.
	input wire io_master_awready,
	output logic io_master_awvalid,
	output logic [addr_width-1:0] io_master_awaddr,
	output logic [id_width-1:0] io_master_awid,
	output logic [len_width-1:0] io_master_awlen,
	output logic [size_width-1:0] io_master_awsize,
	output logic [burst_width-1:0] io_master_awburst,
	input wire io_master_wready,
	output logic io_master_wvalid,
	output logic [data_width-1:0] io_master_wdata,
	output logic [strb_width-1:0] io_master_wstrb,
	output logic io_master_wlast,
	output logic io_master_bready,
	input wire io_master_bvalid,
	input wire [resp_width-1:0] io_master_bresp,
	input wire [id_width-1:0] io_master_bid,
	input wire io_master_arready,
	output logic io_master_arvalid,
	output logic [addr_width-1:0] io_master_araddr,
	output logic [id_width-1:0] io_master_arid,
	output logic [len_width-1:0] io_master_arlen,
	output logic [size_width-1:0] io_master_arsize,
	output logic [burst_width-1:0] io_master_arburst,
	output logic io_master_rready,
	input wire io_master_rvalid,
	input wire [resp_width-1:0] io_master_rresp,
	input wire [data_width-1:0] io_master_rdata,
	input wire io_master_rlast,
	input wire [id_width-1:0] io_master_rid
);

	grant_state_t grant_state;
	grant_state_t next_state;
	grant_state_t route_state;

	logic lsu_is_clint;
	logic ifu_read_done;
	logic lsu_read_done;
	logic clint_read_done;
	logic lsu_write_done;

	assign lsu_is_clint = (lsu_araddr >= clint_base) && (lsu_araddr <= clint_limit);

	// Completing handshakes, one per owner.
	assign ifu_read_done = io_master_rvalid && ifu_rready && io_master_rlast;
	assign lsu_read_done = io_master_rvalid && lsu_rready && io_master_rlast;
	assign clint_read_done = clint_rvalid && lsu_rready && clint_rlast;
	assign lsu_write_done = io_master_bvalid && lsu_bready;

	always_ff @(posedge clock) begin
		if (reset) begin
			grant_state <= grant_idle;
		end else begin
			grant_state <= next_state;
		end
	end

	always_comb begin
		next_state = grant_state;
		case (grant_state)
			grant_idle: begin
				// Fixed priority. ifu read first, lsu write last.
				if (ifu_arvalid) begin
					next_state = grant_ifu_read;
				end else if (lsu_arvalid && lsu_is_clint) begin
					next_state = grant_clint_read;
				end else if (lsu_arvalid) begin
					next_state = grant_lsu_read;
				end else if (lsu_awvalid) begin
					next_state = grant_lsu_write;
				end
			end
			grant_ifu_read: begin
				if (ifu_read_done) begin
					next_state = grant_idle;
				end
			end
			grant_lsu_read: begin
				if (lsu_read_done) begin
					next_state = grant_idle;
				end
			end
			grant_clint_read: begin
				if (clint_read_done) begin
					next_state = grant_idle;
				end
			end
			grant_lsu_write: begin
				if (lsu_write_done) begin
					next_state = grant_idle;
				end
			end
			default: begin
				next_state = grant_idle;
			end
		endcase
	end

	// A fresh grant routes in the cycle it is won; an owner keeps the
	// route through its completing beat.
	assign route_state = (grant_state == grant_idle) ? next_state : grant_state;

	// Handshake signals follow the owner, all others stay low.
	always_comb begin
		ifu_arready = 1'b0;
		ifu_rvalid = 1'b0;
		lsu_arready = 1'b0;
		lsu_rvalid = 1'b0;
		lsu_awready = 1'b0;
		lsu_wready = 1'b0;
		lsu_bvalid = 1'b0;
		clint_arvalid = 1'b0;
		clint_rready = 1'b0;
		io_master_arvalid = 1'b0;
		io_master_rready = 1'b0;
		io_master_awvalid = 1'b0;
		io_master_wvalid = 1'b0;
		io_master_bready = 1'b0;
		case (route_state)
			grant_ifu_read: begin
				io_master_arvalid = ifu_arvalid;
				ifu_arready = io_master_arready;
				ifu_rvalid = io_master_rvalid;
				io_master_rready = ifu_rready;
			end
			grant_lsu_read: begin
				io_master_arvalid = lsu_arvalid;
				lsu_arready = io_master_arready;
				lsu_rvalid = io_master_rvalid;
				io_master_rready = lsu_rready;
			end
			grant_clint_read: begin
				clint_arvalid = lsu_arvalid;
				lsu_arready = clint_arready;
				lsu_rvalid = clint_rvalid;
				clint_rready = lsu_rready;
			end
			grant_lsu_write: begin
				io_master_awvalid = lsu_awvalid;
				lsu_awready = io_master_awready;
				io_master_wvalid = lsu_wvalid;
				lsu_wready = io_master_wready;
				lsu_bvalid = io_master_bvalid;
				io_master_bready = lsu_bready;
			end
			default: begin
			end
		endcase
	end

	// Payload is qualified by the valid signals above.
	assign io_master_araddr = (route_state == grant_ifu_read) ? ifu_araddr : lsu_araddr;
	assign io_master_arid = (route_state == grant_ifu_read) ? ifu_arid : lsu_arid;
	assign io_master_arlen = (route_state == grant_ifu_read) ? ifu_arlen : lsu_arlen;
	assign io_master_arsize = (route_state == grant_ifu_read) ? ifu_arsize : lsu_arsize;
	assign io_master_arburst = (route_state == grant_ifu_read) ? ifu_arburst : lsu_arburst;

	assign clint_araddr = lsu_araddr;
	assign clint_arid = lsu_arid;
	assign clint_arlen = lsu_arlen;
	assign clint_arsize = lsu_arsize;
	assign clint_arburst = lsu_arburst;

	// Write channels only ever come from the lsu.
	assign io_master_awaddr = lsu_awaddr;
	assign io_master_awid = lsu_awid;
	assign io_master_awlen = lsu_awlen;
	assign io_master_awsize = lsu_awsize;
	assign io_master_awburst = lsu_awburst;
	assign io_master_wdata = lsu_wdata;
	assign io_master_wstrb = lsu_wstrb;
	assign io_master_wlast = lsu_wlast;
	assign lsu_bresp = io_master_bresp;
	assign lsu_bid = io_master_bid;

	assign ifu_rresp = io_master_rresp;
	assign ifu_rdata = io_master_rdata;
	assign ifu_rlast = io_master_rlast;
	assign ifu_rid = io_master_rid;

	// lsu read data from the CLINT or the external port.
	assign lsu_rresp = (route_state == grant_clint_read) ? clint_rresp : io_master_rresp;
	assign lsu_rdata = (route_state == grant_clint_read) ? clint_rdata : io_master_rdata;
	assign lsu_rlast = (route_state == grant_clint_read) ? clint_rlast : io_master_rlast;
	assign lsu_rid = (route_state == grant_clint_read) ? clint_rid : io_master_rid;

endmodule

`default_nettype wire

/* hw/clint.sv */
`timescale 1ns/1ps
`default_nettype none

module clint import core_bus_pkg::*; (
	input wire clock,
	input wire reset,

	// Read address.
	input wire arvalid,
	input wire [addr_width-1:0] araddr,
	input wire [id_width-1:0] arid,
	input wire [len_width-1:0] arlen,
	input wire [size_width-1:0] arsize,
	input wire [burst_width-1:0] arburst,
	output logic arready,

	// Read data.
	input wire rready,
	output logic rvalid,
	output axi_resp_t rresp,
	output logic [data_width-1:0] rdata,
	output logic rlast,
	output logic [id_width-1:0] rid
);

	logic [data_width-1:0] mtime;
	logic ar_fire;
	logic r_fire;

	// One response in flight, new address only once it has drained.
	assign arready = !rvalid;
	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;

	// Every response is a single beat.
	// arlen, arsize and arburst are accepted but not examined.
	assign rlast = 1'b1;

	// Free-running machine timer.
	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (r_fire) begin
			rvalid <= 1'b0;
		end
	end

	// Response payload, captured with the address.
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rid <= arid;
			if (araddr == clint_mtime_addr) begin
				rdata <= mtime;
				rresp <= resp_okay;
			end else begin
				rdata <= '0;
				rresp <= resp_slverr;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/core_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module core_bus import core_bus_pkg::*; (
	input wire clock,
	input wire reset,

	// Instruction fetch read.
	input wire ifu_arvalid,
	input wire [addr_width-1:0] ifu_araddr,
	input wire [id_width-1:0] ifu_arid,
	input wire [len_width-1:0] ifu_arlen,
	input wire [size_width-1:0] ifu_arsize,
	input wire [burst_width-1:0] ifu_arburst,
	input wire ifu_rready,
	output logic ifu_arready,
	output logic ifu_rvalid,
	output logic [resp_width-1:0] ifu_rresp,
	output logic [data_width-1:0] ifu_rdata,
	output logic ifu_rlast,
	output logic [id_width-1:0] ifu_rid,

	// Load/store read.
	input wire lsu_arvalid,
	input wire [addr_width-1:0] lsu_araddr,
	input wire [id_width-1:0] lsu_arid,
	input wire [len_width-1:0] lsu_arlen,
	input wire [size_width-1:0] lsu_arsize,
	input wire [burst_width-1:0] lsu_arburst,
	input wire lsu_rready,
	output logic lsu_arready,
	output logic lsu_rvalid,
	output logic [resp_width-1:0] lsu_rresp,
	output logic [data_width-1:0] lsu_rdata,
	output logic lsu_rlast,
	output logic [id_width-1:0] lsu_rid,

	// Load/store write.
	input wire lsu_awvalid,
	input wire [addr_width-1:0] lsu_awaddr,
	input wire [id_width-1:0] lsu_awid,
	input wire [len_width-1:0] lsu_awlen,
	input wire [size_width-1:0] lsu_awsize,
	input wire [burst_width-1:0] lsu_awburst,
	input wire lsu_wvalid,
	input wire [data_width-1:0] lsu_wdata,
	input wire [strb_width-1:0] lsu_wstrb,
	input wire lsu_wlast,
	input wire lsu_bready,
	output logic lsu_awready,
	output logic lsu_wready,
	output logic lsu_bvalid,
	output logic [resp_width-1:0] lsu_bresp,
	output logic [id_width-1:0] lsu_bid,

	// External AXI4 master port.
	input wire io_master_awready,
	output logic io_master_awvalid,
	output logic [addr_width-1:0] io_master_awaddr,
	output logic [id_width-1:0] io_master_awid,
	output logic [len_width-1:0] io_master_awlen,
	output logic [size_width-1:0] io_master_awsize,
	output logic [burst_width-1:0] io_master_awburst,
	input wire io_master_wready,
	output logic io_master_wvalid,
	output logic [data_width-1:0] io_master_wdata,
	output logic [strb_width-1:0] io_master_wstrb,
	output logic io_master_wlast,
	output logic io_master_bready,
	input wire io_master_bvalid,
	input wire [resp_width-1:0] io_master_bresp,
	input wire [id_width-1:0] io_master_bid,
	input wire io_master_arready,
	output logic io_master_arvalid,
	output logic [addr_width-1:0] io_master_araddr,
	output logic [id_width-1:0] io_master_arid,
	output logic [len_width-1:0] io_master_arlen,
	output logic [size_width-1:0] io_master_arsize,
	output logic [burst_width-1:0] io_master_arburst,
	output logic io_master_rready,
	input wire io_master_rvalid,
	input wire [resp_width-1:0] io_master_rresp,
	input wire [data_width-1:0] io_master_rdata,
	input wire io_master_rlast,
	input wire [id_width-1:0] io_master_rid
);

	// Interconnect to CLINT.
	logic clint_arvalid;
	logic [addr_width-1:0] clint_araddr;
	logic [id_width-1:0] clint_arid;
	logic [len_width-1:0] clint_arlen;
	logic [size_width-1:0] clint_arsize;
	logic [burst_width-1:0] clint_arburst;
	logic clint_arready;
	logic clint_rready;
	logic clint_rvalid;
	logic [resp_width-1:0] clint_rresp;
	logic [data_width-1:0] clint_rdata;
	logic clint_rlast;
	logic [id_width-1:0] clint_rid;

	// Port names match the top level one to one.
	axi_interconnect u_interconnect (.*);

	clint u_clint (
		.clock(clock),
		.reset(reset),
		.arvalid(clint_arvalid),
		.araddr(clint_araddr),
		.arid(clint_arid),
		.arlen(clint_arlen),
		.arsize(clint_arsize),
		.arburst(clint_arburst),
		.arready(clint_arready),
		.rready(clint_rready),
		.rvalid(clint_rvalid),
		.rresp(clint_rresp),
		.rdata(clint_rdata),
		.rlast(clint_rlast),
		.rid(clint_rid)
	);

endmodule

`default_nettype wire

/* verification/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import core_bus_pkg::*; (
	input wire clock,
	input wire reset,
	// Back-pressure per channel. Bit 0 ar, 1 r, 2 aw, 3 w.
	input wire [3:0] stall,
	input wire io_master_arvalid,
	input wire [addr_width-1:0] io_master_araddr,
	input wire [id_width-1:0] io_master_arid,
	input wire [len_width-1:0] io_master_arlen,
	output logic io_master_arready,
	input wire io_master_rready,
	output logic io_master_rvalid,
	output logic [resp_width-1:0] io_master_rresp,
	output logic [data_width-1:0] io_master_rdata,
	output logic io_master_rlast,
	output logic [id_width-1:0] io_master_rid,
	input wire io_master_awvalid,
	input wire [addr_width-1:0] io_master_awaddr,
	input wire [id_width-1:0] io_master_awid,
	output logic io_master_awready,
	input wire io_master_wvalid,
	input wire [data_width-1:0] io_master_wdata,
	input wire [strb_width-1:0] io_master_wstrb,
	input wire io_master_wlast,
	output logic io_master_wready,
	input wire io_master_bready,
	output logic io_master_bvalid,
	output logic [resp_width-1:0] io_master_bresp,
	output logic [id_width-1:0] io_master_bid
);

	logic [data_width-1:0] mem [0:255];
	logic [data_width-1:0] merged;
	logic rd_busy;
	logic [addr_width-1:0] rd_addr;
	logic [len_width-1:0] rd_left;
	logic wr_busy;
	logic [addr_width-1:0] wr_addr;

	// Each word starts as its byte address, tagged in the upper half.
	initial begin
		logic [31:0] byte_addr;
		rd_busy = 1'b0;
		wr_busy = 1'b0;
		io_master_rvalid = 1'b0;
		io_master_rdata = '0;
		io_master_rlast = 1'b0;
		io_master_rid = '0;
		io_master_bvalid = 1'b0;
		io_master_bid = '0;
		for (int i = 0; i < 256; i++) begin
			byte_addr = i * 8;
			mem[i] = {32'ha5a5_0000 | byte_addr, byte_addr};
		end
	end

	assign io_master_arready = !rd_busy && !stall[0];
	assign io_master_awready = !wr_busy && !stall[2];
	assign io_master_wready = wr_busy && !io_master_bvalid && !stall[3];
	assign io_master_rresp = resp_okay;
	assign io_master_bresp = resp_okay;

	// INCR read burst, one 8-byte beat per handshake.
	always @(posedge clock) begin
		if (reset) begin
			rd_busy <= 1'b0;
			io_master_rvalid <= 1'b0;
		end else if (io_master_arvalid && io_master_arready) begin
			rd_busy <= 1'b1;
			rd_addr <= io_master_araddr;
			rd_left <= io_master_arlen;
			io_master_rid <= io_master_arid;
		end else if (io_master_rvalid && io_master_rready) begin
			io_master_rvalid <= 1'b0;
			rd_busy <= !io_master_rlast;
			rd_addr <= rd_addr + 8;
			rd_left <= rd_left - 1'b1;
		end else if (rd_busy && !io_master_rvalid && !stall[1]) begin
			io_master_rvalid <= 1'b1;
			io_master_rdata <= mem[rd_addr[10:3]];
			io_master_rlast <= (rd_left == 0);
		end
	end

	// Write burst ends on wlast, then one response.
	always @(posedge clock) begin
		if (reset) begin
			wr_busy <= 1'b0;
			io_master_bvalid <= 1'b0;
		end else begin
			if (io_master_awvalid && io_master_awready) begin
				wr_busy <= 1'b1;
				wr_addr <= io_master_awaddr;
				io_master_bid <= io_master_awid;
			end
			if (io_master_wvalid && io_master_wready) begin
				merged = mem[wr_addr[10:3]];
				for (int i = 0; i < strb_width; i++) begin
					if (io_master_wstrb[i]) begin
						merged[i*8 +: 8] = io_master_wdata[i*8 +: 8];
					end
				end
				mem[wr_addr[10:3]] <= merged;
				wr_addr <= wr_addr + 8;
				io_master_bvalid <= io_master_wlast;
			end
			if (io_master_bvalid && io_master_bready) begin
				io_master_bvalid <= 1'b0;
				wr_busy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verification/core_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_bus_tb import core_bus_pkg::*; ();

	typedef enum {ifu_ar, ifu_r, lsu_ar, lsu_r, lsu_aw, lsu_w, lsu_b} channel_t;

	logic clock;
	logic reset;
	logic [3:0] stall;
	logic ifu_arvalid, ifu_rready, ifu_arready, ifu_rvalid, ifu_rlast;
	logic lsu_arvalid, lsu_rready, lsu_arready, lsu_rvalid, lsu_rlast;
	logic lsu_awvalid, lsu_wvalid, lsu_wlast, lsu_bready, lsu_awready, lsu_wready, lsu_bvalid;
	logic io_master_arvalid, io_master_arready, io_master_rvalid, io_master_rready;
	logic io_master_rlast, io_master_awvalid, io_master_awready, io_master_wvalid;
	logic io_master_wready, io_master_wlast, io_master_bvalid, io_master_bready;
	logic [addr_width-1:0] ifu_araddr, lsu_araddr, lsu_awaddr, io_master_araddr, io_master_awaddr;
	logic [id_width-1:0] ifu_arid, ifu_rid, lsu_arid, lsu_rid, lsu_awid, lsu_bid;
	logic [id_width-1:0] io_master_arid, io_master_rid, io_master_awid, io_master_bid;
	logic [len_width-1:0] ifu_arlen, lsu_arlen, lsu_awlen, io_master_arlen, io_master_awlen;
	logic [size_width-1:0] ifu_arsize, lsu_arsize, lsu_awsize, io_master_arsize, io_master_awsize;
	logic [burst_width-1:0] ifu_arburst, lsu_arburst, lsu_awburst;
	logic [burst_width-1:0] io_master_arburst, io_master_awburst;
	logic [resp_width-1:0] ifu_rresp, lsu_rresp, lsu_bresp, io_master_rresp, io_master_bresp;
	logic [data_width-1:0] ifu_rdata, lsu_rdata, lsu_wdata, io_master_rdata, io_master_wdata;
	logic [strb_width-1:0] lsu_wstrb, io_master_wstrb;

	logic [31:0] stall_state = 32'd97;
	logic [31:0] hold_state = 32'd97;
	int cycle = 0;
	int ext_ar_cycles = 0;
	int ifu_last_cycle;
	int lsu_ar_cycle;
	int lsu_first_cycle;
	logic [data_width-1:0] read_words [0:7];
	logic [data_width-1:0] write_words [0:1];
	logic [resp_width-1:0] read_resp;

	core_bus uut (.*);
	axi_mem_model memory (.*);

	always #5 clock = ~clock;

	// Memory back-pressure, about one cycle in four per channel.
	always @(negedge clock) begin
		stall_state = next_random(stall_state);
		stall <= stall_state[31:28] & stall_state[27:24];
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (io_master_arvalid) begin
			ext_ar_cycles <= ext_ar_cycles + 1;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] value);
		return value * 32'd1103515245 + 32'd12345;
	endfunction

	// Power-on content of the external memory.
	function automatic logic [63:0] initial_word(input logic [31:0] addr);
		return {32'ha5a5_0000 | addr, addr};
	endfunction

	function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
		input logic [63:0] new_word, input logic [7:0] strb);
		logic [63:0] result;
		result = old_word;
		for (int i = 0; i < 8; i++) begin
			if (strb[i]) begin
				result[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return result;
	endfunction

	function automatic logic handshake_ready(input channel_t channel);
		case (channel)
			ifu_ar: return ifu_arready;
			ifu_r: return ifu_rvalid;
			lsu_ar: return lsu_arready;
			lsu_r: return lsu_rvalid;
			lsu_aw: return lsu_awready;
			lsu_w: return lsu_wready;
			default: return lsu_bvalid;
		endcase
	endfunction

	task automatic compare(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	// Returns on the rising edge where the handshake completes.
	task automatic await_handshake(input channel_t channel);
		int waited;
		grant_state_t state;
		waited = 0;
		@(posedge clock);
		while (!handshake_ready(channel)) begin
			waited++;
			if (waited > 200) begin
				state = uut.u_interconnect.grant_state;
				$display("Timeout: %s channel stalled in grant state %s",
					channel.name(), state.name());
				$display("ERRORS FOUND");
				$fatal(1, "Stopped on a stalled channel.");
			end
			@(posedge clock);
		end
	endtask

	// Fetch burst, checked beat by beat against the initial memory.
	task automatic ifu_read(input logic [31:0] addr, input logic [3:0] id, input int len,
		input logic hold);
		int beat;
		@(negedge clock);
		ifu_araddr = addr;
		ifu_arid = id;
		ifu_arlen = len - 1;
		ifu_arsize = 3'd3;
		ifu_arburst = 2'b01;
		ifu_arvalid = 1'b1;
		await_handshake(ifu_ar);
		compare("io_master_araddr", io_master_araddr, addr);
		compare("io_master_arlen", io_master_arlen, len - 1);
		compare("io_master_arsize", io_master_arsize, 3'd3);
		compare("io_master_arburst", io_master_arburst, 2'b01);
		@(negedge clock);
		ifu_arvalid = 1'b0;
		ifu_rready = !hold;
		for (beat = 0; beat < len; beat++) begin
			if (hold) begin
				hold_state = next_random(hold_state);
				@(negedge clock);
				ifu_rready = 1'b0;
				repeat (1 + hold_state[25:24]) @(negedge clock);
				ifu_rready = 1'b1;
			end
			await_handshake(ifu_r);
			compare("ifu_rdata", ifu_rdata, initial_word(addr + 8 * beat));
			compare("ifu_rid", ifu_rid, id);
			compare("ifu_rresp", ifu_rresp, resp_okay);
			compare("ifu_rlast", ifu_rlast, beat == len - 1);
			if (beat == len - 1) begin
				ifu_last_cycle = cycle;
			end
		end
		@(negedge clock);
		ifu_rready = 1'b0;
	endtask

	task automatic lsu_read(input logic [31:0] addr, input logic [3:0] id, input int len);
		int beat;
		@(negedge clock);
		lsu_araddr = addr;
		lsu_arid = id;
		lsu_arlen = len - 1;
		lsu_arsize = 3'd3;
		lsu_arburst = 2'b01;
		lsu_arvalid = 1'b1;
		lsu_rready = 1'b1;
		await_handshake(lsu_ar);
		lsu_ar_cycle = cycle;
		@(negedge clock);
		lsu_arvalid = 1'b0;
		for (beat = 0; beat < len; beat++) begin
			await_handshake(lsu_r);
			if (beat == 0) begin
				lsu_first_cycle = cycle;
			end
			read_words[beat] = lsu_rdata;
			read_resp = lsu_rresp;
			compare("lsu_rid", lsu_rid, id);
			compare("lsu_rlast", lsu_rlast, beat == len - 1);
		end
		@(negedge clock);
		lsu_rready = 1'b0;
	endtask

	// Two-beat write of write_words with one strobe for both beats.
	task automatic lsu_write(input logic [31:0] addr, input logic [3:0] id,
		input logic [7:0] strb);
		int beat;
		@(negedge clock);
		lsu_awaddr = addr;
		lsu_awid = id;
		lsu_awlen = 8'd1;
		lsu_awsize = 3'd3;
		lsu_awburst = 2'b01;
		lsu_awvalid = 1'b1;
		await_handshake(lsu_aw);
		compare("io_master_awaddr", io_master_awaddr, addr);
		compare("io_master_awlen", io_master_awlen, 8'd1);
		compare("io_master_awsize", io_master_awsize, 3'd3);
		compare("io_master_awburst", io_master_awburst, 2'b01);
		for (beat = 0; beat < 2; beat++) begin
			@(negedge clock);
			lsu_awvalid = 1'b0;
			lsu_wdata = write_words[beat];
			lsu_wstrb = strb;
			lsu_wlast = (beat == 1);
			lsu_wvalid = 1'b1;
			await_handshake(lsu_w);
		end
		@(negedge clock);
		lsu_wvalid = 1'b0;
		lsu_bready = 1'b1;
		await_handshake(lsu_b);
		compare("lsu_bresp", lsu_bresp, resp_okay);
		compare("lsu_bid", lsu_bid, id);
		@(negedge clock);
		lsu_bready = 1'b0;
	endtask

	task automatic fetch_burst_test();
		ifu_read(32'h40, 4'h3, 4, 1'b0);
	endtask

	task automatic partial_write_test();
		write_words[0] = 64'h1122_3344_5566_7788;
		write_words[1] = 64'h99aa_bbcc_ddee_ff00;
		lsu_write(32'h100, 4'h5, 8'b0011_1100);
		lsu_read(32'h100, 4'h6, 2);
		compare("lsu_rresp", read_resp, resp_okay);
		for (int i = 0; i < 2; i++) begin
			compare("lsu_rdata", read_words[i],
				merge_bytes(initial_word(32'h100 + 8 * i), write_words[i], 8'b0011_1100));
		end
	endtask

	// Both reads raised on the same edge, ifu wins.
	task automatic arbitration_test();
		fork
			ifu_read(32'h200, 4'h1, 2, 1'b0);
			lsu_read(32'h300, 4'h2, 1);
			begin
				@(negedge clock);
				@(posedge clock);
				compare("io_master_arvalid", io_master_arvalid, 1'b1);
				compare("io_master_arid", io_master_arid, 4'h1);
				compare("io_master_araddr", io_master_araddr, 32'h200);
			end
		join
		compare("lsu ar after ifu rlast", lsu_ar_cycle > ifu_last_cycle, 1'b1);
		compare("lsu_rdata", read_words[0], initial_word(32'h300));
	endtask

	task automatic timer_read_test();
		logic [63:0] first_time;
		int first_cycle;
		int ext_before;
		ext_before = ext_ar_cycles;
		lsu_read(clint_mtime_addr, 4'h7, 1);
		compare("lsu_rresp", read_resp, resp_okay);
		compare("clint rvalid delay", lsu_first_cycle - lsu_ar_cycle, 1);
		first_time = read_words[0];
		first_cycle = lsu_ar_cycle;
		repeat (5) @(negedge clock);
		lsu_read(clint_mtime_addr, 4'h8, 1);
		compare("lsu_rresp", read_resp, resp_okay);
		compare("clint rvalid delay", lsu_first_cycle - lsu_ar_cycle, 1);
		compare("mtime step", read_words[0] - first_time, lsu_ar_cycle - first_cycle);
		compare("io_master_arvalid cycles", ext_ar_cycles, ext_before);
	endtask

	task automatic clint_error_test();
		lsu_read(clint_base, 4'h9, 1);
		compare("lsu_rresp", read_resp, resp_slverr);
		compare("lsu_rdata", read_words[0], 64'h0);
	endtask

	task automatic fetch_backpressure_test();
		ifu_read(32'h80, 4'hc, 4, 1'b1);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		stall = '0;
		ifu_arvalid = 1'b0;
		ifu_araddr = '0;
		ifu_arid = '0;
		ifu_arlen = '0;
		ifu_arsize = '0;
		ifu_arburst = '0;
		ifu_rready = 1'b0;
		lsu_arvalid = 1'b0;
		lsu_araddr = '0;
		lsu_arid = '0;
		lsu_arlen = '0;
		lsu_arsize = '0;
		lsu_arburst = '0;
		lsu_rready = 1'b0;
		lsu_awvalid = 1'b0;
		lsu_awaddr = '0;
		lsu_awid = '0;
		lsu_awlen = '0;
		lsu_awsize = '0;
		lsu_awburst = '0;
		lsu_wvalid = 1'b0;
		lsu_wdata = '0;
		lsu_wstrb = '0;
		lsu_wlast = 1'b0;
		lsu_bready = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		// Nothing moves out of reset.
		compare("io_master_arvalid", io_master_arvalid, 1'b0);
		compare("io_master_awvalid", io_master_awvalid, 1'b0);
		compare("lsu_rvalid", lsu_rvalid, 1'b0);
		fetch_burst_test();
		partial_write_test();
		arbitration_test();
		timer_read_test();
		clint_error_test();
		fetch_backpressure_test();
		repeat (5) @(negedge clock);
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* core_bus.f */
hw/core_bus_pkg.sv
hw/axi_interconnect.sv
hw/clint.sv
hw/core_bus.sv
verification/axi_mem_model.sv
verification/core_bus_tb.sv
